// File: build.f
common/fruit_pkg.sv
common/slot_ctrl_if.sv
common/slot_status_if.sv
src/spawn_unit.sv
slot/fruit_slot.sv
src/score_tally.sv
src/fruit_field.sv
verif/field_checker.sv
verif/tb_fruit_field.sv

// File: common/fruit_pkg.sv
package fruit_pkg;

    // slot pool
    localparam int NUM_SLOTS  = 4;
    localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);

    // visible area in pixels
    localparam int SCREEN_W = 640;
    localparam int SCREEN_H = 480;

    // fruit box and launch geometry
    localparam int HALF_SIZE   = 31;                          // half edge of the square box
    localparam int LAUNCH_Y    = SCREEN_H + HALF_SIZE - 1;    // just below the bottom edge
    localparam int EDGE_MARGIN = 100;

    // physics, per frame
    localparam int GRAVITY    = 1;
    localparam int SPLIT_STEP = 2;

    // widths
    localparam int COORD_W = 12;
    localparam int CNT_W   = 16;

    typedef logic signed [COORD_W-1:0] coord_t;   // position or velocity
    typedef logic [1:0] kind_t;

    typedef enum logic [1:0] {
        SLOT_EMPTY  = 2'b00,
        SLOT_WHOLE  = 2'b01,
        SLOT_HALVES = 2'b10
    } slot_state_t;

endpackage

// File: common/slot_ctrl_if.sv
`timescale 1ns/1ps

interface slot_ctrl_if;
    import fruit_pkg::*;

    logic [NUM_SLOTS-1:0] launch_sel;   // one-hot pulse, values valid with it
    coord_t               launch_x;
    coord_t               launch_vx;
    coord_t               launch_vy;
    kind_t                launch_kind;

    modport launcher (
        output launch_sel,
        output launch_x,
        output launch_vx,
        output launch_vy,
        output launch_kind
    );

    modport slot (
        input launch_sel,
        input launch_x,
        input launch_vx,
        input launch_vy,
        input launch_kind
    );

endinterface

// File: common/slot_status_if.sv
`timescale 1ns/1ps

interface slot_status_if;
    import fruit_pkg::*;

    // each slot drives its own bit
    logic [NUM_SLOTS-1:0] busy;       // state not empty
    logic [NUM_SLOTS-1:0] cut_evt;    // whole fruit just split
    logic [NUM_SLOTS-1:0] miss_evt;   // whole fruit just left the screen

    modport reporter (
        output busy,
        output cut_evt,
        output miss_evt
    );

    modport picker (
        input busy
    );

    modport counter (
        input cut_evt,
        input miss_evt
    );

endinterface

// File: slot/fruit_slot.sv
`timescale 1ns/1ps

module fruit_slot #(
    parameter int slot_id = 0
) (
    input  logic                    Clk,
    input  logic                    rst_n,
    input  logic                    frame_tick,
    input  logic                    cut_req,
    input  fruit_pkg::coord_t       cursor_x,
    input  fruit_pkg::coord_t       cursor_y,
    slot_ctrl_if.slot               ctrl,
    slot_status_if.reporter         status,
    output fruit_pkg::slot_state_t  state,
    output fruit_pkg::coord_t       pos_x,
    output fruit_pkg::coord_t       pos_y,
    output fruit_pkg::kind_t        kind
);
    import fruit_pkg::*;

    coord_t                  vel_x;
    coord_t                  vel_y;
    coord_t                  spread;   // distance of each half from the pair centre
    logic signed [COORD_W:0] dx;
    logic signed [COORD_W:0] dy;
    logic                    launch;
    logic                    hit;
    logic                    below;
    logic                    off_side;
    logic                    pair_off_side;
    logic                    leave;
    logic                    cut_evt_q;
    logic                    miss_evt_q;

    assign launch = ctrl.launch_sel[slot_id];

    // cursor offset from the box centre
    assign dx = cursor_x - pos_x;
    assign dy = cursor_y - pos_y;

    assign hit = cut_req && (state == SLOT_WHOLE)
                 && (dx >= -HALF_SIZE) && (dx <= HALF_SIZE)
                 && (dy >= -HALF_SIZE) && (dy <= HALF_SIZE);

    assign below    = (vel_y > 0) && (pos_y > SCREEN_H + HALF_SIZE);
    assign off_side = (pos_x < -HALF_SIZE) || (pos_x > SCREEN_W + HALF_SIZE);

    // both halves past the same side, judged by the inner one
    assign pair_off_side = ((pos_x + spread) < -HALF_SIZE)
                           || ((pos_x - spread) > SCREEN_W + HALF_SIZE);

    always_comb
    begin
        unique case (state)
            SLOT_WHOLE:  leave = below || off_side;
            SLOT_HALVES: leave = below || pair_off_side;
            default:     leave = 1'b0;
        endcase
    end

    always_ff @(posedge Clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= SLOT_EMPTY;
            cut_evt_q  <= 1'b0;
            miss_evt_q <= 1'b0;
            pos_x      <= '0;
            pos_y      <= '0;
            vel_x      <= '0;
            vel_y      <= '0;
            kind       <= '0;
            spread     <= '0;
        end
        else
        begin
            cut_evt_q  <= 1'b0;
            miss_evt_q <= 1'b0;
            if (launch)
            begin
                state  <= SLOT_WHOLE;
                pos_x  <= ctrl.launch_x;
                pos_y  <= coord_t'(LAUNCH_Y);
                vel_x  <= ctrl.launch_vx;
                vel_y  <= ctrl.launch_vy;
                kind   <= ctrl.launch_kind;
                spread <= '0;
            end
            else if (hit)
            begin
                state     <= SLOT_HALVES;   // velocity kept, no motion this frame
                spread    <= '0;
                cut_evt_q <= 1'b1;
            end
            else if (frame_tick && (state != SLOT_EMPTY))
            begin
                if (leave)
                begin
                    state      <= SLOT_EMPTY;
                    miss_evt_q <= (state == SLOT_WHOLE);   // halves leave silently
                end
                else
                begin
                    pos_x <= pos_x + vel_x;
                    pos_y <= pos_y + vel_y;
                    vel_y <= vel_y + coord_t'(GRAVITY);
                    if (state == SLOT_HALVES)
                    begin
                        spread <= spread + coord_t'(SPLIT_STEP);
                    end
                end
            end
        end
    end

    assign status.busy[slot_id]     = (state != SLOT_EMPTY);
    assign status.cut_evt[slot_id]  = cut_evt_q;
    assign status.miss_evt[slot_id] = miss_evt_q;

    // halves only become a whole fruit again through a new launch
    a_halves_no_revive: assert property (@(posedge Clk) disable iff (!rst_n)
        (state == SLOT_HALVES) && !launch |=> (state != SLOT_WHOLE))
        else $error("slot %0d went from halves to whole without launch", slot_id);

    a_evt_exclusive: assert property (@(posedge Clk) disable iff (!rst_n)
        !(cut_evt_q && miss_evt_q))
        else $error("slot %0d raised cut and miss together", slot_id);

endmodule

// File: src/fruit_field.sv
`timescale 1ns/1ps

module fruit_field (
    input  logic                         Clk,
    input  logic                         rst_n,
    input  logic                         frame_tick,
    input  logic                         spawn_req,
    input  logic [15:0]                  random_word,
    input  logic                         cut_req,
    input  fruit_pkg::coord_t            cursor_x,
    input  fruit_pkg::coord_t            cursor_y,
    input  logic                         score_clear,
    output fruit_pkg::slot_state_t       slot_state [fruit_pkg::NUM_SLOTS],
    output fruit_pkg::coord_t            slot_x [fruit_pkg::NUM_SLOTS],
    output fruit_pkg::coord_t            slot_y [fruit_pkg::NUM_SLOTS],
    output fruit_pkg::kind_t             slot_kind [fruit_pkg::NUM_SLOTS],
    output logic                         launch_ok,
    output logic [fruit_pkg::CNT_W-1:0]  total_cut,
    output logic [fruit_pkg::CNT_W-1:0]  total_miss
);
    import fruit_pkg::*;

    slot_ctrl_if   ctrl_bus ();
    slot_status_if status_bus ();

    spawn_unit u_spawn (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .spawn_req   (spawn_req),
        .random_word (random_word),
        .ctrl        (ctrl_bus.launcher),
        .status      (status_bus.picker),
        .launch_ok   (launch_ok)
    );

    for (genvar i = 0; i < NUM_SLOTS; i++)
    begin : g_slot
        fruit_slot #(
            .slot_id (i)
        ) u_slot (
            .Clk        (Clk),
            .rst_n      (rst_n),
            .frame_tick (frame_tick),
            .cut_req    (cut_req),
            .cursor_x   (cursor_x),
            .cursor_y   (cursor_y),
            .ctrl       (ctrl_bus.slot),
            .status     (status_bus.reporter),
            .state      (slot_state[i]),
            .pos_x      (slot_x[i]),
            .pos_y      (slot_y[i]),
            .kind       (slot_kind[i])
        );
    end

    score_tally u_tally (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .score_clear (score_clear),
        .status      (status_bus.counter),
        .total_cut   (total_cut),
        .total_miss  (total_miss)
    );

endmodule

// File: src/score_tally.sv
`timescale 1ns/1ps

module score_tally (
    input  logic                         Clk,
    input  logic                         rst_n,
    input  logic                         score_clear,
    slot_status_if.counter               status,
    output logic [fruit_pkg::CNT_W-1:0]  total_cut,
    output logic [fruit_pkg::CNT_W-1:0]  total_miss
);
    import fruit_pkg::*;

    function automatic logic [SLOT_IDX_W:0] popcount(input logic [NUM_SLOTS-1:0] evt);
        logic [SLOT_IDX_W:0] cnt;
        cnt = '0;
        for (int i = 0; i < NUM_SLOTS; i++)
        begin
            cnt = cnt + evt[i];
        end
        return cnt;
    endfunction

    // sticks at all ones instead of wrapping
    function automatic logic [CNT_W-1:0] sat_add(input logic [CNT_W-1:0] total,
                                                 input logic [SLOT_IDX_W:0] inc);
        logic [CNT_W:0] sum;
        sum = {1'b0, total} + inc;
        return sum[CNT_W] ? '1 : sum[CNT_W-1:0];
    endfunction

    logic [SLOT_IDX_W:0] cut_cnt;
    logic [SLOT_IDX_W:0] miss_cnt;

    assign cut_cnt  = popcount(status.cut_evt);
    assign miss_cnt = popcount(status.miss_evt);

    always_ff @(posedge Clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            total_cut  <= '0;
            total_miss <= '0;
        end
        else if (score_clear)
        begin
            total_cut  <= '0;   // events of this cycle are dropped
            total_miss <= '0;
        end
        else
        begin
            total_cut  <= sat_add(total_cut, cut_cnt);
            total_miss <= sat_add(total_miss, miss_cnt);
        end
    end

    a_totals_monotonic: assert property (@(posedge Clk) disable iff (!rst_n)
        !score_clear |=> (total_cut >= $past(total_cut)) && (total_miss >= $past(total_miss)))
        else $error("a total decreased without score_clear");

endmodule

// File: src/spawn_unit.sv
`timescale 1ns/1ps

module spawn_unit (
    input  logic          Clk,
    input  logic          rst_n,
    input  logic          spawn_req,
    input  logic [15:0]   random_word,
    slot_ctrl_if.launcher ctrl,
    slot_status_if.picker status,
    output logic          launch_ok
);
    import fruit_pkg::*;

    logic [NUM_SLOTS-1:0] free_mask;
    logic [NUM_SLOTS-1:0] pick;
    coord_t               offs_x;
    coord_t               speed_x;
    coord_t               x_val;
    coord_t               vx_val;
    coord_t               vy_val;

    assign launch_ok = ~&status.busy;

    // a slot launched last cycle is not busy yet, keep it out of the pick
    assign free_mask = ~status.busy & ~ctrl.launch_sel;
    assign pick      = free_mask & (~free_mask + 1'b1);   // lowest set bit only

    // launch values from the random word
    assign offs_x  = coord_t'(random_word[10:4]);
    assign speed_x = coord_t'(random_word[12:11]) + coord_t'(1);

    always_comb
    begin
        if (random_word[3])
        begin
            x_val  = coord_t'(EDGE_MARGIN) + offs_x;   // left zone, flies right
            vx_val = speed_x;
        end
        else
        begin
            x_val  = coord_t'(SCREEN_W - EDGE_MARGIN) - offs_x;
            vx_val = -speed_x;
        end
    end

    assign vy_val = coord_t'(random_word[14:13]) - coord_t'(11);   // -11 .. -8, upward

    always_ff @(posedge Clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ctrl.launch_sel <= '0;
        end
        else
        begin
            ctrl.launch_sel <= spawn_req ? pick : '0;   // dropped when nothing is free
        end
    end

    always_ff @(posedge Clk)
    begin
        if (spawn_req)
        begin
            ctrl.launch_x    <= x_val;
            ctrl.launch_vx   <= vx_val;
            ctrl.launch_vy   <= vy_val;
            ctrl.launch_kind <= random_word[2:1];
        end
    end

    // the pulse never targets a slot that is already holding a fruit
    a_launch_onehot_free: assert property (@(posedge Clk) disable iff (!rst_n)
        $onehot0(ctrl.launch_sel) && ((ctrl.launch_sel & status.busy) == '0))
        else $error("launch_sel not one-hot or points at a busy slot");

endmodule

// File: verif/field_checker.sv
`timescale 1ns/1ps

module field_checker (
    input  logic                         Clk,
    input  logic                         rst_n,
    input  logic                         frame_tick,
    input  logic                         spawn_req,
    input  logic [15:0]                  random_word,
    input  logic                         cut_req,
    input  fruit_pkg::coord_t            cursor_x,
    input  fruit_pkg::coord_t            cursor_y,
    input  logic                         score_clear,
    input  fruit_pkg::slot_state_t       slot_state [fruit_pkg::NUM_SLOTS],
    input  fruit_pkg::coord_t            slot_x [fruit_pkg::NUM_SLOTS],
    input  fruit_pkg::coord_t            slot_y [fruit_pkg::NUM_SLOTS],
    input  fruit_pkg::kind_t             slot_kind [fruit_pkg::NUM_SLOTS],
    input  logic                         launch_ok,
    input  logic [fruit_pkg::CNT_W-1:0]  total_cut,
    input  logic [fruit_pkg::CNT_W-1:0]  total_miss,
    input  logic                         row_done,
    input  int                           row_idx,
    input  logic                         row_cut,
    input  logic                         row_hit,
    output int                           rows_passed,
    output int                           rows_failed,
    output int                           err_total
);
    import fruit_pkg::*;

    localparam int TOTAL_MAX = (1 << CNT_W) - 1;

    // reference pool with one entry per slot
    int                   m_st [NUM_SLOTS];
    int                   m_x [NUM_SLOTS];
    int                   m_y [NUM_SLOTS];
    int                   m_vx [NUM_SLOTS];
    int                   m_vy [NUM_SLOTS];
    int                   m_kind [NUM_SLOTS];
    int                   m_spread [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] m_lsel;     // launch pulse of the spawn stage
    int                   m_lx;
    int                   m_lvx;
    int                   m_lvy;
    int                   m_lkind;
    logic [NUM_SLOTS-1:0] m_cut;
    logic [NUM_SLOTS-1:0] m_miss;
    int                   m_tc;
    int                   m_tm;
    slot_state_t          last_state [NUM_SLOTS];   // DUT state at the previous falling edge
    int                   row_errs;
    int                   row_cuts;

    function automatic int add_capped(input int total, input int n);
        return (total + n > TOTAL_MAX) ? TOTAL_MAX : total + n;
    endfunction

    function automatic bit near(input int a, input int b);
        return (a - b >= -HALF_SIZE) && (a - b <= HALF_SIZE);
    endfunction

    task automatic flag_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        err_total++;
        row_errs++;
    endtask

    task automatic reset_model();
        for (int i = 0; i < NUM_SLOTS; i++)
        begin
            m_st[i]       = int'(SLOT_EMPTY);
            m_spread[i]   = 0;
            last_state[i] = SLOT_EMPTY;
        end
        m_lsel      = '0;
        m_cut       = '0;
        m_miss      = '0;
        m_tc        = 0;
        m_tm        = 0;
        row_errs    = 0;
        row_cuts    = 0;
        rows_passed = 0;
        rows_failed = 0;
        err_total   = 0;
    endtask

    task automatic compare_outputs();
        bit all_busy;
        all_busy = 1'b1;
        for (int i = 0; i < NUM_SLOTS; i++)
        begin
            if (m_st[i] == int'(SLOT_EMPTY))
                all_busy = 1'b0;
            if (slot_state[i] !== slot_state_t'(m_st[i]))
                flag_error($sformatf("slot %0d state %0d, expected %0d",
                                     i, slot_state[i], m_st[i]));
            else if (m_st[i] != int'(SLOT_EMPTY))
            begin
                if (slot_x[i] !== coord_t'(m_x[i]) || slot_y[i] !== coord_t'(m_y[i]))
                    flag_error($sformatf("slot %0d at (%0d,%0d), expected (%0d,%0d)",
                                         i, slot_x[i], slot_y[i], m_x[i], m_y[i]));
                if (slot_kind[i] !== kind_t'(m_kind[i]))
                    flag_error($sformatf("slot %0d kind %0d, expected %0d",
                                         i, slot_kind[i], m_kind[i]));
            end
        end
        if (launch_ok !== !all_busy)
            flag_error($sformatf("launch_ok %b, expected %b", launch_ok, !all_busy));
        if (total_cut !== m_tc[CNT_W-1:0])
            flag_error($sformatf("total_cut %0d, expected %0d", total_cut, m_tc));
        if (total_miss !== m_tm[CNT_W-1:0])
            flag_error($sformatf("total_miss %0d, expected %0d", total_miss, m_tm));
    endtask

    // a whole fruit of the DUT that turned into halves
    task automatic count_dut_cuts();
        for (int i = 0; i < NUM_SLOTS; i++)
        begin
            if (last_state[i] == SLOT_WHOLE && slot_state[i] == SLOT_HALVES)
                row_cuts++;
            last_state[i] = slot_state[i];
        end
    endtask

    task automatic step_model();
        logic [NUM_SLOTS-1:0] busy;
        logic [NUM_SLOTS-1:0] sel;
        logic [NUM_SLOTS-1:0] cuts;
        logic [NUM_SLOTS-1:0] misses;
        int                   cx;
        int                   cy;
        int                   offs;
        int                   speed;
        bit                   gone;
        cx     = cursor_x;
        cy     = cursor_y;
        busy   = '0;
        sel    = '0;
        cuts   = '0;
        misses = '0;
        for (int i = 0; i < NUM_SLOTS; i++)
            busy[i] = (m_st[i] != int'(SLOT_EMPTY));
        if (spawn_req)
        begin
            for (int i = NUM_SLOTS - 1; i >= 0; i--)   // last match is the lowest free slot
            begin
                if (!busy[i] && !m_lsel[i])
                begin
                    sel    = '0;
                    sel[i] = 1'b1;
                end
            end
        end
        if (score_clear)
        begin
            m_tc = 0;
            m_tm = 0;
        end
        else
        begin
            m_tc = add_capped(m_tc, $countones(m_cut));
            m_tm = add_capped(m_tm, $countones(m_miss));
        end
        for (int i = 0; i < NUM_SLOTS; i++)
        begin
            if (m_lsel[i])
            begin
                m_st[i]     = int'(SLOT_WHOLE);
                m_x[i]      = m_lx;
                m_y[i]      = LAUNCH_Y;
                m_vx[i]     = m_lvx;
                m_vy[i]     = m_lvy;
                m_kind[i]   = m_lkind;
                m_spread[i] = 0;
            end
            else if (cut_req && m_st[i] == int'(SLOT_WHOLE)
                     && near(cx, m_x[i]) && near(cy, m_y[i]))
            begin
                m_st[i]     = int'(SLOT_HALVES);
                m_spread[i] = 0;
                cuts[i]     = 1'b1;
            end
            else if (frame_tick && m_st[i] != int'(SLOT_EMPTY))
            begin
                gone = (m_vy[i] > 0) && (m_y[i] > SCREEN_H + HALF_SIZE);
                if (m_st[i] == int'(SLOT_WHOLE))
                    gone = gone || (m_x[i] < -HALF_SIZE) || (m_x[i] > SCREEN_W + HALF_SIZE);
                else
                    gone = gone || (m_x[i] + m_spread[i] < -HALF_SIZE)
                           || (m_x[i] - m_spread[i] > SCREEN_W + HALF_SIZE);
                if (gone)
                begin
                    misses[i] = (m_st[i] == int'(SLOT_WHOLE));   // halves leave without a miss
                    m_st[i]   = int'(SLOT_EMPTY);
                end
                else
                begin
                    m_x[i]  = m_x[i] + m_vx[i];
                    m_y[i]  = m_y[i] + m_vy[i];
                    m_vy[i] = m_vy[i] + GRAVITY;
                    if (m_st[i] == int'(SLOT_HALVES))
                        m_spread[i] = m_spread[i] + SPLIT_STEP;
                end
            end
        end
        if (spawn_req)
        begin
            offs    = int'(random_word[10:4]);
            speed   = 1 + int'(random_word[12:11]);
            m_lx    = random_word[3] ? EDGE_MARGIN + offs : SCREEN_W - EDGE_MARGIN - offs;
            m_lvx   = random_word[3] ? speed : -speed;
            m_lvy   = int'(random_word[14:13]) - 11;
            m_lkind = int'(random_word[2:1]);
        end
        m_lsel = sel;
        m_cut  = cuts;
        m_miss = misses;
    endtask

    task automatic report_row();
        if (row_cut && ((row_cuts > 0) != row_hit))
            flag_error($sformatf("row %0d cut hit %0d, expected %0d",
                                 row_idx, row_cuts > 0, row_hit));
        if (row_errs == 0)
        begin
            $display("row %0d: ok", row_idx);
            rows_passed++;
        end
        else
        begin
            $display("row %0d: %0d mismatches", row_idx, row_errs);
            rows_failed++;
        end
        row_errs = 0;
        row_cuts = 0;
    endtask

    // outputs have settled by the falling edge and the inputs are those of the next rising edge
    always @(negedge Clk)
    begin
        if (!rst_n)
            reset_model();
        else
        begin
            compare_outputs();
            count_dut_cuts();
            step_model();
            if (row_done)
                report_row();
        end
    end

endmodule

// File: verif/tb_fruit_field.sv
`timescale 1ns/1ps

module tb_fruit_field;
    import fruit_pkg::*;

    localparam int OP_SPAWN     = 0;
    localparam int OP_CUT_SLOT  = 1;   // arg is offset * 16 + slot
    localparam int OP_CUT_POINT = 2;   // arg is x << 16 | y
    localparam int OP_FRAMES    = 3;
    localparam int OP_CLEAR     = 4;   // arg >= 0 cuts that slot the cycle before
    localparam int NUM_ROWS     = 17;
    localparam int CYCLE_LIMIT  = NUM_ROWS * 80 + 100;

    int op_tab  [NUM_ROWS] = '{OP_SPAWN, OP_FRAMES, OP_SPAWN, OP_SPAWN, OP_SPAWN, OP_FRAMES,
                               OP_SPAWN, OP_CUT_SLOT, OP_CUT_POINT, OP_CUT_SLOT, OP_FRAMES,
                               OP_SPAWN, OP_CLEAR, OP_FRAMES, OP_SPAWN, OP_FRAMES, OP_CLEAR};
    int arg_tab [NUM_ROWS] = '{2, 5, 1, 2, 1, 26,
                               1, 40 * 16, 32'h0005_0005, 31 * 16, 26,
                               1, 0, 26, 1, 26, -1};
    bit hit_tab [NUM_ROWS] = '{0, 0, 0, 0, 0, 0,
                               0, 0, 0, 1, 0,
                               0, 1, 0, 0, 0, 0};

    logic                Clk;
    logic                rst_n;
    logic                frame_tick;
    logic                spawn_req;
    logic [15:0]         random_word;
    logic                cut_req;
    coord_t              cursor_x;
    coord_t              cursor_y;
    logic                score_clear;
    slot_state_t         slot_state [NUM_SLOTS];
    coord_t              slot_x [NUM_SLOTS];
    coord_t              slot_y [NUM_SLOTS];
    kind_t               slot_kind [NUM_SLOTS];
    logic                launch_ok;
    logic [CNT_W-1:0]    total_cut;
    logic [CNT_W-1:0]    total_miss;
    logic                row_done;
    int                  row_idx;
    logic                row_cut;
    logic                row_hit;
    int                  rows_passed;
    int                  rows_failed;
    int                  err_total;
    logic [31:0]         lfsr;
    int                  cycles;

    fruit_field DUT (
        .Clk (Clk), .rst_n (rst_n), .frame_tick (frame_tick), .spawn_req (spawn_req),
        .random_word (random_word), .cut_req (cut_req), .cursor_x (cursor_x),
        .cursor_y (cursor_y), .score_clear (score_clear), .slot_state (slot_state),
        .slot_x (slot_x), .slot_y (slot_y), .slot_kind (slot_kind), .launch_ok (launch_ok),
        .total_cut (total_cut), .total_miss (total_miss)
    );

    field_checker u_checker (
        .Clk (Clk), .rst_n (rst_n), .frame_tick (frame_tick), .spawn_req (spawn_req),
        .random_word (random_word), .cut_req (cut_req), .cursor_x (cursor_x),
        .cursor_y (cursor_y), .score_clear (score_clear), .slot_state (slot_state),
        .slot_x (slot_x), .slot_y (slot_y), .slot_kind (slot_kind), .launch_ok (launch_ok),
        .total_cut (total_cut), .total_miss (total_miss), .row_done (row_done),
        .row_idx (row_idx), .row_cut (row_cut), .row_hit (row_hit),
        .rows_passed (rows_passed), .rows_failed (rows_failed), .err_total (err_total)
    );

    always #50 Clk = ~Clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_random_word();
        for (int b = 0; b < 16; b++)
        begin
            lfsr           = lfsr_step(lfsr);
            random_word[b] = lfsr[0];
        end
    endtask

    task automatic next_edge();
        @(posedge Clk);
        #1;
    endtask

    task automatic aim_at_slot(input int slot, input int off);
        cursor_x = slot_x[slot] + coord_t'(off);
        cursor_y = slot_y[slot] + coord_t'(off);
    endtask

    task automatic run_row(input int i);
        row_idx = i;
        row_hit = hit_tab[i];
        row_cut = (op_tab[i] == OP_CUT_SLOT) || (op_tab[i] == OP_CUT_POINT)
                  || (op_tab[i] == OP_CLEAR && arg_tab[i] >= 0);
        case (op_tab[i])
            OP_SPAWN:
            begin
                repeat (arg_tab[i])
                begin
                    spawn_req = 1'b1;
                    draw_random_word();
                    next_edge();
                end
                spawn_req = 1'b0;
            end
            OP_CUT_SLOT, OP_CUT_POINT:
            begin
                if (op_tab[i] == OP_CUT_SLOT)
                    aim_at_slot(arg_tab[i] % 16, arg_tab[i] / 16);
                else
                begin
                    cursor_x = coord_t'(arg_tab[i] >>> 16);
                    cursor_y = coord_t'(arg_tab[i] & 32'hffff);
                end
                cut_req = 1'b1;
                next_edge();
                cut_req = 1'b0;
            end
            OP_FRAMES:
            begin
                repeat (arg_tab[i])
                begin
                    frame_tick = 1'b1;
                    next_edge();
                    frame_tick = 1'b0;
                    next_edge();
                end
            end
            default:
            begin
                if (arg_tab[i] >= 0)
                begin
                    aim_at_slot(arg_tab[i], 0);
                    cut_req = 1'b1;
                    next_edge();
                    cut_req = 1'b0;
                end
                score_clear = 1'b1;   // lands in the cycle of the cut event
                next_edge();
                score_clear = 1'b0;
            end
        endcase
        repeat (3) next_edge();
        row_done = 1'b1;
        next_edge();
        row_done = 1'b0;
    endtask

    initial
    begin
        Clk         = 1'b0;
        rst_n       = 1'b0;
        frame_tick  = 1'b0;
        spawn_req   = 1'b0;
        random_word = '0;
        cut_req     = 1'b0;
        cursor_x    = '0;
        cursor_y    = '0;
        score_clear = 1'b0;
        row_done    = 1'b0;
        row_idx     = 0;
        row_cut     = 1'b0;
        row_hit     = 1'b0;
        lfsr        = 32'hddd6e821;
        repeat (5) @(posedge Clk);
        #1 rst_n = 1'b1;
        next_edge();
        for (int i = 0; i < NUM_ROWS; i++)
            run_row(i);
        repeat (2) next_edge();
        $display("rows passed %0d, rows failed %0d, errors %0d", rows_passed, rows_failed, err_total);
        if (rows_failed == 0 && err_total == 0 && rows_passed == NUM_ROWS)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge Clk);
            cycles++;
        end
        $display("run timed out after %0d cycles without finishing the rows", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

endmodule
